/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pre_fetch
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Simulation FAILED

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
VECTORS   := test/pre_fetch_vectors.txt

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+include
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/itlb_lookup.sv
logic/fetch_req_merge.sv
logic/pre_fetch_stage.sv
test/tb_pre_fetch.sv

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// boot rom entry
`define RESET_PC        32'hBFC0_0000

// general exception entry
`define GENERAL_EX_PC   32'hBFC0_0380

// tlb refill entry
`define REFILL_EX_PC    32'hBFC0_0200

// strips the segment bits of kseg0/kseg1
`define KSEG_PHYS_MASK  32'h1FFF_FFFF

// page frame number, also the vpn width
`define PFN_W           20

// icache geometry
`define INDEX_W         8
`define OFFSET_W        4

// cache attribute field of a tlb page half
`define TLB_C_W         3

// exception code field
`define EXC_CODE_W      5

`endif

/* logic/fetch_pkg.sv */
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

    // cp0 cause codes seen at fetch
    typedef enum logic [`EXC_CODE_W-1:0] {
        exc_tlbl = 5'd2,   // tlb refill or invalid on fetch
        exc_adel = 5'd4,   // misaligned fetch address
        exc_none = 5'd31
    } exc_code_e;

    // one-entry instruction translation buffer
    typedef enum logic {
        buf_empty = 1'b0,
        buf_valid = 1'b1
    } itlb_state_e;

    // from decode
    typedef struct packed {
        logic        stall;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // one half of a tlb entry, even or odd page
    typedef struct packed {
        logic [`PFN_W-1:0]   pfn;
        logic [`TLB_C_W-1:0] c;   // cache attribute
        logic                d;
        logic                v;
    } tlb_page_t;

    // combinational answer of the joint tlb
    typedef struct packed {
        logic      found;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_resp_t;

    // pre-fetch to fetch stage record
    typedef struct packed {
        logic        inst_valid;
        logic        bd_next;     // instruction after a delay slot
        logic [31:0] pc;
        logic        ex;
        logic        tlb_refill;
        exc_code_e   exc_code;
    } fetch_bus_t;

endpackage

`default_nettype wire

/* logic/fetch_req_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_req_merge (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [31:0]                 pc,
    input  wire [`PFN_W-1:0]           pfn,
    input  wire                        tlb_ex,
    input  wire                        tlb_refill,
    input  wire                        bd_next,
    input  wire                        allowin,
    input  wire                        icache_busy,
    input  wire                        buf_stall,
    input  wire                        flush,
    input  wire                        refetch,
    output fetch_pkg::fetch_bus_t      fs_bus,
    output logic [`INDEX_W-1:0]        inst_index,
    output logic [`PFN_W-1:0]          inst_tag,
    output logic [`OFFSET_W-1:0]       inst_offset,
    output logic                       inst_valid
);

    import fetch_pkg::*;

    logic      adel;
    logic      ex;
    exc_code_e exc_code;
    logic      flush_pending;
    logic      refetch_pending;

    assign adel = (pc[1:0] != 2'b00);
    assign ex   = adel | tlb_ex;

    always_comb begin
        if (adel) begin
            exc_code = exc_adel;   // alignment checked first
        end else if (tlb_ex) begin
            exc_code = exc_tlbl;
        end else begin
            exc_code = exc_none;
        end
    end

    // remember a redirect until the cache has drained
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_pending   <= 1'b0;
            refetch_pending <= 1'b0;
        end else begin
            if (flush) begin
                flush_pending <= 1'b1;
            end else if (~icache_busy) begin
                flush_pending <= 1'b0;
            end
            if (refetch) begin
                refetch_pending <= 1'b1;
            end else if (~icache_busy) begin
                refetch_pending <= 1'b0;
            end
        end
    end

    always_comb begin
        if (flush_pending & ~icache_busy & ~refetch_pending) begin
            inst_valid = 1'b1;     // first fetch from the new vector
        end else if (ex | buf_stall) begin
            inst_valid = 1'b0;
        end else begin
            inst_valid = allowin & ~icache_busy & ~refetch_pending;
        end
    end

    assign inst_index  = pc[`INDEX_W+`OFFSET_W-1:`OFFSET_W];
    assign inst_offset = pc[`OFFSET_W-1:0];
    assign inst_tag    = pfn;

    assign fs_bus = '{
        inst_valid : inst_valid,
        bd_next    : bd_next,
        pc         : pc,
        ex         : ex,
        tlb_refill : tlb_refill & ~adel,   // only when the tlb fault is reported
        exc_code   : exc_code
    };

endmodule

`default_nettype wire

/* logic/itlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module itlb_lookup (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [31:0]                pc,
    input  wire fetch_pkg::tlb_resp_t tlb_resp,
    input  wire                       tlb_flush,
    output logic [`PFN_W-1:0]         tlb_vpn,
    output logic [`PFN_W-1:0]         pfn,
    output logic                      buf_stall,
    output logic                      tlb_ex,
    output logic                      tlb_refill
);

    import fetch_pkg::*;

    itlb_state_e       state;
    logic [`PFN_W-1:0] buf_vpn;
    tlb_resp_t         buf_resp;
    tlb_resp_t         cur_resp;
    tlb_page_t         page;
    logic [31:0]       phys_addr;
    logic              unmapped;
    logic              hit;
    logic              miss;
    logic              page_invalid;

    assign tlb_vpn = pc[31:12];

    // kseg0 and kseg1 bypass translation
    assign unmapped  = (pc[31:30] == 2'b10);
    assign phys_addr = pc & `KSEG_PHYS_MASK;

    assign hit  = (state == buf_valid) && (buf_vpn == tlb_vpn);
    assign miss = ~unmapped & ~hit;

    // buffered entry on a hit, live tlb answer while missing
    assign cur_resp = hit ? buf_resp : tlb_resp;

    // vpn bit 0 picks the odd page
    assign page = tlb_vpn[0] ? cur_resp.page1 : cur_resp.page0;

    // one cycle to capture a found entry, misses without a match never stall
    assign buf_stall = miss & tlb_resp.found;

    assign tlb_refill   = miss & ~tlb_resp.found;
    assign page_invalid = ~unmapped & cur_resp.found & ~page.v;
    assign tlb_ex       = tlb_refill | page_invalid;

    assign pfn = unmapped ? phys_addr[31:12] : page.pfn;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= buf_empty;
        end else if (tlb_flush) begin
            state <= buf_empty;   // tlbwi/tlbwr may have changed the entry
        end else if (buf_stall) begin
            state <= buf_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_stall) begin
            buf_vpn  <= tlb_vpn;
            buf_resp <= tlb_resp;
        end
    end

    // pc is held while stalling, so the captured entry hits next cycle
    property p_single_stall;
        @(posedge clk) disable iff (reset)
        (buf_stall && !tlb_flush) |=> !buf_stall;
    endproperty

    a_single_stall: assert property (p_single_stall)
        else $error("itlb buf_stall lasted more than one cycle");

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_gen (
    input  wire                     clk,
    input  wire                     reset,
    input  wire fetch_pkg::br_bus_t br_bus,
    input  wire                     flush,
    input  wire                     flush_refill,
    input  wire                     eret,
    input  wire [31:0]              epc,
    input  wire                     refetch,
    input  wire [31:0]              refetch_pc,
    input  wire                     fs_allowin,
    input  wire                     icache_busy,
    input  wire                     buf_stall,
    output logic [31:0]             pc,
    output logic                    allowin,
    output logic                    ready_go,
    output logic                    bd_next
);

    logic [31:0] next_pc;
    logic [31:0] seq_pc;
    logic        pc_load;

    assign seq_pc   = pc + 32'd4;
    assign ready_go = ~icache_busy & ~buf_stall;
    assign allowin  = flush | (fs_allowin & ready_go);
    assign pc_load  = (allowin & ~icache_busy) | flush;

    // a taken branch in decode means the current pc sits past the delay slot
    assign bd_next = br_bus.taken;

    // eret wins over flush, flush over branch
    always_comb begin
        if (eret) begin
            next_pc = epc;
        end else if (flush) begin
            if (flush_refill) begin
                next_pc = `REFILL_EX_PC;
            end else if (refetch) begin
                next_pc = refetch_pc;   // replay from the memory stage
            end else begin
                next_pc = `GENERAL_EX_PC;
            end
        end else if (br_bus.taken) begin
            next_pc = br_bus.target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // busy cache freezes the address unless an exception redirects it
    property p_hold_while_busy;
        @(posedge clk) disable iff (reset)
        (icache_busy && !flush) |=> (pc == $past(pc));
    endproperty

    a_hold_while_busy: assert property (p_hold_while_busy)
        else $error("pc loaded while icache_busy was high without flush");

endmodule

`default_nettype wire

/* logic/pre_fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pre_fetch_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire fetch_pkg::br_bus_t   br_bus,
    input  wire                       fs_allowin,
    input  wire                       flush,
    input  wire                       flush_refill,
    input  wire                       eret,
    input  wire [31:0]                epc,
    input  wire                       refetch,
    input  wire [31:0]                refetch_pc,
    input  wire                       icache_busy,
    output logic [`PFN_W-1:0]         tlb_vpn,
    input  wire fetch_pkg::tlb_resp_t tlb_resp,
    input  wire                       tlb_flush,
    output fetch_pkg::fetch_bus_t     fs_bus,
    output logic                      fs_valid,
    output logic [`INDEX_W-1:0]       inst_index,
    output logic [`PFN_W-1:0]         inst_tag,
    output logic [`OFFSET_W-1:0]      inst_offset,
    output logic                      inst_valid,
    output logic [31:0]               pc
);

    logic              allowin;
    logic              ready_go;
    logic              bd_next;
    logic              buf_stall;
    logic [`PFN_W-1:0] pfn;
    logic              tlb_ex;
    logic              tlb_refill;

    assign fs_valid = ready_go;

    pc_gen u_pc_gen (
        .clk          (clk),
        .reset        (reset),
        .br_bus       (br_bus),
        .flush        (flush),
        .flush_refill (flush_refill),
        .eret         (eret),
        .epc          (epc),
        .refetch      (refetch),
        .refetch_pc   (refetch_pc),
        .fs_allowin   (fs_allowin),
        .icache_busy  (icache_busy),
        .buf_stall    (buf_stall),
        .pc           (pc),
        .allowin      (allowin),
        .ready_go     (ready_go),
        .bd_next      (bd_next)
    );

    itlb_lookup u_itlb_lookup (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .tlb_resp   (tlb_resp),
        .tlb_flush  (tlb_flush),
        .tlb_vpn    (tlb_vpn),
        .pfn        (pfn),
        .buf_stall  (buf_stall),
        .tlb_ex     (tlb_ex),
        .tlb_refill (tlb_refill)
    );

    fetch_req_merge u_fetch_req_merge (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .pfn         (pfn),
        .tlb_ex      (tlb_ex),
        .tlb_refill  (tlb_refill),
        .bd_next     (bd_next),
        .allowin     (allowin),
        .icache_busy (icache_busy),
        .buf_stall   (buf_stall),
        .flush       (flush),
        .refetch     (refetch),
        .fs_bus      (fs_bus),
        .inst_index  (inst_index),
        .inst_tag    (inst_tag),
        .inst_offset (inst_offset),
        .inst_valid  (inst_valid)
    );

endmodule

`default_nettype wire

/* test/pre_fetch_vectors.txt */
// ctrl addr tlb pfn0 pfn1 | expected: pc inst_valid fs_valid exc_code tlb_refill inst_tag
// ctrl: 100 random busy tail, 80 taken, 40 flush, 20 refill, 10 eret, 08 refetch, 04 allowin, 02 busy, 01 tlb_flush; tlb: 4 found, 2 v1, 1 v0
004 00000000 0 00000 00000  BFC00000 1 1 1F 0 1FC00
004 00000000 0 00000 00000  BFC00004 1 1 1F 0 1FC00
004 00000000 0 00000 00000  BFC00008 1 1 1F 0 1FC00
000 00000000 0 00000 00000  BFC0000C 0 1 1F 0 1FC00
006 00000000 0 00000 00000  BFC0000C 0 0 1F 0 1FC00
004 00000000 0 00000 00000  BFC0000C 1 1 1F 0 1FC00
084 BFC00100 0 00000 00000  BFC00010 1 1 1F 0 1FC00
004 00000000 0 00000 00000  BFC00100 1 1 1F 0 1FC00
084 00400000 0 00000 00000  BFC00104 1 1 1F 0 1FC00
004 00000000 7 12340 56781  00400000 0 0 1F 0 12340
004 00000000 0 00000 00000  00400000 1 1 1F 0 12340
004 00000000 0 00000 00000  00400004 1 1 1F 0 12340
084 00401000 0 00000 00000  00400008 1 1 1F 0 12340
004 00000000 7 12340 56781  00401000 0 0 1F 0 56781
005 00000000 0 00000 00000  00401000 1 1 1F 0 56781
004 00000000 7 12340 56781  00401004 0 0 1F 0 56781
004 00000000 0 00000 00000  00401004 1 1 1F 0 56781
084 00800000 0 00000 00000  00401008 1 1 1F 0 56781
000 00000000 0 00000 00000  00800000 0 1 02 1 00000
060 00000000 0 00000 00000  00800000 0 1 02 1 00000
004 00000000 0 00000 00000  BFC00200 1 1 1F 0 1FC00
084 00C00000 0 00000 00000  BFC00204 1 1 1F 0 1FC00
004 00000000 6 0ABC0 0DEF1  00C00000 0 0 02 0 0ABC0
000 00000000 0 00000 00000  00C00000 0 1 02 0 0ABC0
040 00000000 0 00000 00000  00C00000 0 1 02 0 0ABC0
004 00000000 0 00000 00000  BFC00380 1 1 1F 0 1FC00
014 80001002 0 00000 00000  BFC00384 1 1 1F 0 1FC00
000 00000000 0 00000 00000  80001002 0 1 04 0 00001
050 80000100 0 00000 00000  80001002 0 1 04 0 00001
004 00000000 0 00000 00000  80000100 1 1 1F 0 00000
048 80000040 0 00000 00000  80000104 1 1 1F 0 00000
004 00000000 0 00000 00000  80000040 0 1 1F 0 00000
004 00000000 0 00000 00000  80000044 1 1 1F 0 00000
104 00000000 0 00000 00000  00000000 0 0 00 0 00000
104 00000000 0 00000 00000  00000000 0 0 00 0 00000
104 00000000 0 00000 00000  00000000 0 0 00 0 00000
104 00000000 0 00000 00000  00000000 0 0 00 0 00000
FFF 00000000 0 00000 00000  00000000 0 0 00 0 00000

/* test/tb_pre_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_pre_fetch;

    import fetch_pkg::*;

    localparam int NUM_COLS      = 11;
    localparam int MAX_LINES     = 64;
    localparam int MEM_DEPTH     = NUM_COLS * MAX_LINES;
    localparam int IDX_W         = $clog2(MEM_DEPTH);
    localparam int RESET_TIMEOUT = 20;
    localparam int RAND_TAIL_BIT = 8;
    localparam logic [31:0] END_MARK = 32'h0000_0FFF;

    // column order of the vector file
    localparam int COL_CTRL = 0;
    localparam int COL_ADDR = 1;
    localparam int COL_TLB  = 2;
    localparam int COL_PFN0 = 3;
    localparam int COL_PFN1 = 4;
    localparam int COL_PC   = 5;
    localparam int COL_IV   = 6;
    localparam int COL_FV   = 7;
    localparam int COL_EXC  = 8;
    localparam int COL_RF   = 9;
    localparam int COL_TAG  = 10;

    logic                 clk;
    logic                 reset;
    br_bus_t              br_bus;
    logic                 fs_allowin;
    logic                 flush;
    logic                 flush_refill;
    logic                 eret;
    logic [31:0]          epc;
    logic                 refetch;
    logic [31:0]          refetch_pc;
    logic                 icache_busy;
    logic [`PFN_W-1:0]    tlb_vpn;
    tlb_resp_t            tlb_resp;
    logic                 tlb_flush;
    fetch_bus_t           fs_bus;
    logic                 fs_valid;
    logic [`INDEX_W-1:0]  inst_index;
    logic [`PFN_W-1:0]    inst_tag;
    logic [`OFFSET_W-1:0] inst_offset;
    logic                 inst_valid;
    logic [31:0]          pc;

    logic [31:0] vec_mem [0:MEM_DEPTH-1];
    int          num_lines;
    int          cur_line;
    logic        hold_armed;   // busy seen in the random tail
    logic [31:0] hold_pc;

    pre_fetch_stage dut (
        .clk          (clk),
        .reset        (reset),
        .br_bus       (br_bus),
        .fs_allowin   (fs_allowin),
        .flush        (flush),
        .flush_refill (flush_refill),
        .eret         (eret),
        .epc          (epc),
        .refetch      (refetch),
        .refetch_pc   (refetch_pc),
        .icache_busy  (icache_busy),
        .tlb_vpn      (tlb_vpn),
        .tlb_resp     (tlb_resp),
        .tlb_flush    (tlb_flush),
        .fs_bus       (fs_bus),
        .fs_valid     (fs_valid),
        .inst_index   (inst_index),
        .inst_tag     (inst_tag),
        .inst_offset  (inst_offset),
        .inst_valid   (inst_valid),
        .pc           (pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

    function automatic logic [31:0] vec_field(input int idx, input int col);
        logic [IDX_W-1:0] pos;
        pos = IDX_W'(idx * NUM_COLS + col);
        return vec_mem[pos];
    endfunction

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h at vector %0d",
                     name, got, exp, cur_line);
            stop_failed();
        end
    endtask

    // the end marker line closes the table
    task automatic count_vector_lines();
        int idx;
        idx = 0;
        num_lines = -1;
        while (num_lines < 0 && idx < MAX_LINES) begin
            if (vec_field(idx, COL_CTRL) == END_MARK) begin
                num_lines = idx;
            end
            idx++;
        end
        if (num_lines < 0) begin
            $display("no end marker found within %0d vector lines", MAX_LINES);
            stop_failed();
        end
    endtask

    task automatic apply_vector(input int idx);
        logic [31:0] ctrl;
        logic [31:0] addr;
        logic [31:0] tlb;
        logic [31:0] pfn0;
        logic [31:0] pfn1;
        logic [31:0] rand_word;
        ctrl      = vec_field(idx, COL_CTRL);
        addr      = vec_field(idx, COL_ADDR);
        tlb       = vec_field(idx, COL_TLB);
        pfn0      = vec_field(idx, COL_PFN0);
        pfn1      = vec_field(idx, COL_PFN1);
        rand_word = $urandom;
        br_bus.stall  = 1'b0;
        br_bus.taken  = ctrl[7];
        br_bus.target = addr;
        flush         = ctrl[6];
        flush_refill  = ctrl[5];
        eret          = ctrl[4];
        refetch       = ctrl[3];
        fs_allowin    = ctrl[2];
        icache_busy   = ctrl[RAND_TAIL_BIT] ? rand_word[0] : ctrl[1];
        tlb_flush     = ctrl[0];
        epc           = addr;   // one address column serves all redirects
        refetch_pc    = addr;
        tlb_resp.found      = tlb[2];
        tlb_resp.page1.v    = tlb[1];
        tlb_resp.page0.v    = tlb[0];
        tlb_resp.page0.pfn  = pfn0[`PFN_W-1:0];
        tlb_resp.page1.pfn  = pfn1[`PFN_W-1:0];
        tlb_resp.page0.c    = 3'd3;
        tlb_resp.page1.c    = 3'd3;
        tlb_resp.page0.d    = 1'b0;
        tlb_resp.page1.d    = 1'b0;
    endtask

    task automatic check_vector(input int idx);
        logic [31:0] ctrl;
        logic [31:0] exp_pc;
        logic [31:0] exp_iv;
        logic [31:0] exp_exc;
        logic        exp_ex;
        logic        exp_bd;
        ctrl    = vec_field(idx, COL_CTRL);
        exp_pc  = vec_field(idx, COL_PC);
        exp_iv  = vec_field(idx, COL_IV);
        exp_exc = vec_field(idx, COL_EXC);
        exp_ex  = (exp_exc[4:0] != 5'h1F);   // any code but none is a fault
        exp_bd  = ctrl[7];                   // taken branch in decode
        if (ctrl[RAND_TAIL_BIT]) begin
            hold_armed = icache_busy & ~flush;
            hold_pc    = pc;
        end else begin
            check_field("pc", pc, exp_pc);
            check_field("fs_bus.pc", fs_bus.pc, exp_pc);
            check_field("inst_valid", {31'd0, inst_valid}, exp_iv);
            check_field("fs_bus.inst_valid", {31'd0, fs_bus.inst_valid}, exp_iv);
            check_field("fs_valid", {31'd0, fs_valid}, vec_field(idx, COL_FV));
            check_field("exc_code", {27'd0, fs_bus.exc_code}, exp_exc);
            check_field("fs_bus.ex", {31'd0, fs_bus.ex}, {31'd0, exp_ex});
            check_field("tlb_refill", {31'd0, fs_bus.tlb_refill}, vec_field(idx, COL_RF));
            check_field("fs_bus.bd_next", {31'd0, fs_bus.bd_next}, {31'd0, exp_bd});
            check_field("inst_tag", {12'd0, inst_tag}, vec_field(idx, COL_TAG));
            check_field("tlb_vpn", {12'd0, tlb_vpn}, {12'd0, exp_pc[31:12]});
            // 16-byte lines, 256 sets
            check_field("inst_index", {24'd0, inst_index}, {24'd0, exp_pc[11:4]});
            check_field("inst_offset", {28'd0, inst_offset}, {28'd0, exp_pc[3:0]});
        end
    endtask

    // pc just after the edge that followed a busy tail cycle
    task automatic check_hold();
        if (hold_armed) begin
            check_field("pc held while icache_busy", pc, hold_pc);
        end
        hold_armed = 1'b0;
    endtask

    initial begin
        int cycles;
        int idx;
        br_bus       = '0;
        fs_allowin   = 1'b0;
        flush        = 1'b0;
        flush_refill = 1'b0;
        eret         = 1'b0;
        epc          = 32'd0;
        refetch      = 1'b0;
        refetch_pc   = 32'd0;
        icache_busy  = 1'b0;
        tlb_resp     = '0;
        tlb_flush    = 1'b0;
        hold_armed   = 1'b0;
        hold_pc      = 32'd0;
        cur_line     = 0;
        void'($urandom(72100));
        $readmemh("test/pre_fetch_vectors.txt", vec_mem);
        count_vector_lines();

        cycles = 0;
        @(posedge clk);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("reset still asserted after %0d cycles", RESET_TIMEOUT);
            stop_failed();
        end
        #1;
        check_field("pc after reset", pc, `RESET_PC);

        for (idx = 0; idx < num_lines; idx++) begin
            cur_line = idx;
            apply_vector(idx);
            #97;   // just before the next edge
            check_vector(idx);
            @(posedge clk);
            #1;
            check_hold();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
